//--- Makefile
TOP = sys_ctl_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f sys_ctl_top.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

//--- rtl/idt_fetch.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module idt_fetch import int_pkg::*; (
  input  logic               or_int_vec,
  input  logic               rst_n,
  input  irq_idx_t           svc_idx,
  input  logic               hi_sel,
  input  logic               capture_lo,
  input  logic [`ADDR_W-1:0] mem_dp_read_data,
  output logic [`ADDR_W-1:0] mem_address,
  output logic [`ADDR_W-1:0] int_fetch_address,
  output logic [`SEL_W-1:0]  int_cs
);

  logic [`ADDR_W-1:0] entry_addr;
  logic [`ADDR_W-1:0] swapped;
  logic [`ADDR_W-1:0] offset_q;
  logic [`ADDR_W-1:0] hi_word_q;

  assign entry_addr  = `IDT_BASE + `ADDR_W'(svc_idx) * `IDT_ENTRY_BYTES;
  assign mem_address = hi_sel ? entry_addr + `IDT_HI_OFFSET : entry_addr;

  // table is stored big endian
  assign swapped = {<<8{mem_dp_read_data}};

  // second word sampled while hi_sel, last sample is the valid beat
  always_ff @(posedge or_int_vec or negedge rst_n) begin
    if (!rst_n) begin
      offset_q  <= '0;
      hi_word_q <= '0;
    end else begin
      if (capture_lo) offset_q <= swapped;
      if (hi_sel) hi_word_q <= swapped;
    end
  end

  assign int_fetch_address = {{(`ADDR_W - `SEL_W){1'b0}}, offset_q[`SEL_W-1:0]};
  assign int_cs            = hi_word_q[`ADDR_W-1 -: `SEL_W];

endmodule

//--- rtl/int_pending.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module int_pending import int_pkg::*; (
  input  logic     or_int_vec,
  input  logic     rst_n,
  input  irq_vec_t int_vec,
  input  logic     grant,
  input  logic     int_clear,
  output logic     pending_int,
  output irq_idx_t svc_idx
);

  irq_vec_t pend_q;
  irq_vec_t clr_mask;
  irq_idx_t first_idx;

  // lowest set bit wins
  always_comb begin
    first_idx = '0;
    for (int i = `IRQ_LINES - 1; i >= 0; i--) begin
      if (pend_q[i]) first_idx = irq_idx_t'(i);
    end
  end

  // only the serviced line is dropped
  assign clr_mask = irq_vec_t'(int_clear) << svc_idx;

  always_ff @(posedge or_int_vec or negedge rst_n) begin
    if (!rst_n) begin
      pend_q  <= '0;
      svc_idx <= '0;
    end else begin
      pend_q <= (pend_q & ~clr_mask) | int_vec;
      if (grant) svc_idx <= first_idx;
    end
  end

  assign pending_int = |pend_q;

endmodule

//--- rtl/int_pkg.sv
`include "sys_ctl_defs.svh"

package int_pkg;

  // one bit per request line
  typedef logic [`IRQ_LINES-1:0] irq_vec_t;

  // line number
  typedef logic [$clog2(`IRQ_LINES)-1:0] irq_idx_t;

  // interrupt sequencer states
  typedef enum logic [2:0] {
    IDLE,
    READ_LO,
    WAIT_LO,
    READ_HI,
    WAIT_HI,
    REDIRECT,
    DECODE
  } int_state_t;

endpackage

//--- rtl/int_seq_fsm.sv
`timescale 1ns/10ps

module int_seq_fsm import int_pkg::*; (
  input  logic or_int_vec,
  input  logic rst_n,
  input  logic pending_int,
  input  logic hold_int,
  input  logic ret_busy,
  input  logic mem_ready,
  input  logic mem_dp_valid,
  output logic mem_valid,
  output logic mem_dp_ready,
  output logic hi_sel,
  output logic capture_lo,
  output logic grant,
  output logic int_clear,
  output logic int_redirect,
  output logic decode_start_int,
  input  logic decode_end_int
);

  int_state_t state_q;
  int_state_t state_d;
  logic       start_q;

  // blocked while software holds off or a return is in flight
  assign grant = (state_q == IDLE) && pending_int && !hold_int && !ret_busy;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:     if (grant) state_d = READ_LO;
      READ_LO:  if (mem_ready) state_d = WAIT_LO;
      WAIT_LO:  if (mem_dp_valid) state_d = READ_HI;
      READ_HI:  if (mem_ready) state_d = WAIT_HI;
      WAIT_HI:  if (mem_dp_valid) state_d = REDIRECT;
      REDIRECT: state_d = DECODE;
      DECODE:   if (decode_end_int) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge or_int_vec or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // first decode cycle only
      start_q <= (state_q == REDIRECT);
    end
  end

  assign mem_valid        = (state_q == READ_LO) || (state_q == READ_HI);
  assign mem_dp_ready     = (state_q == WAIT_LO) || (state_q == WAIT_HI);
  assign hi_sel           = (state_q == READ_HI) || (state_q == WAIT_HI);
  assign capture_lo       = (state_q == WAIT_LO) && mem_dp_valid;
  assign int_redirect     = (state_q == REDIRECT);
  assign int_clear        = int_redirect;
  assign decode_start_int = start_q;

  // read data only returns while a data phase is open
  a_dp_valid_in_wait: assert property (@(posedge or_int_vec) disable iff (!rst_n)
    mem_dp_valid |-> mem_dp_ready);

  // decode reports the end only of a started sequence
  a_end_in_decode: assert property (@(posedge or_int_vec) disable iff (!rst_n)
    decode_end_int |-> (state_q == DECODE));

endmodule

//--- rtl/redirect_merge.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module redirect_merge (
  input  logic               or_int_vec,
  input  logic               rst_n,
  input  logic               int_redirect,
  input  logic [`ADDR_W-1:0] int_fetch_address,
  input  logic [`SEL_W-1:0]  int_cs,
  input  logic               iretd_halt,
  input  logic               ret_load_eflags,
  input  logic               ret_load_cs,
  input  logic               ret_load_eip,
  input  logic               ret_redirect,
  input  logic [`SEL_W-1:0]  ret_cs,
  input  logic [`ADDR_W-1:0] iretd_pop_data,
  input  logic               jump_load,
  input  logic [`ADDR_W-1:0] jump_load_address,
  input  logic               jump_load_cs,
  input  logic [`SEL_W-1:0]  jump_cs,
  output logic               flush_fetch,
  output logic               flush_decode_0,
  output logic               flush_decode_1,
  output logic               flush_register,
  output logic               flush_address,
  output logic               flush_execute,
  output logic               flush_writeback,
  output logic               fetch_load,
  output logic [`ADDR_W-1:0] fetch_load_address,
  output logic               reg_load_cs,
  output logic [`SEL_W-1:0]  reg_cs,
  output logic               reg_load_eflags,
  output logic [`ADDR_W-1:0] reg_eflags,
  output logic               reg_load_eip,
  output logic [`ADDR_W-1:0] reg_eip
);

  logic               jmp_q;
  logic               jmp_load_cs_q;
  logic [`ADDR_W-1:0] jmp_addr_q;
  logic [`SEL_W-1:0]  jmp_cs_q;
  logic               front_flush;

  //////////////////////////////////////////////////
  // jump register

  always_ff @(posedge or_int_vec or negedge rst_n) begin
    if (!rst_n) begin
      jmp_q         <= 1'b0;
      jmp_load_cs_q <= 1'b0;
    end else begin
      jmp_q         <= jump_load;
      jmp_load_cs_q <= jump_load && jump_load_cs;
    end
  end

  always_ff @(posedge or_int_vec) begin
    if (jump_load) begin
      jmp_addr_q <= jump_load_address;
      jmp_cs_q   <= jump_cs;
    end
  end

  //////////////////////////////////////////////////
  // flush and load merge

  // decode through address stages, shared by every redirect
  assign front_flush = int_redirect || ret_redirect || jmp_q;

  assign flush_fetch     = int_redirect || iretd_halt || jmp_q;
  assign flush_decode_0  = front_flush;
  assign flush_decode_1  = front_flush;
  assign flush_register  = front_flush;
  assign flush_address   = front_flush;
  assign flush_execute   = int_redirect || jmp_q;
  assign flush_writeback = int_redirect;

  assign fetch_load  = front_flush;
  assign reg_load_cs = int_redirect || ret_load_cs || jmp_load_cs_q;

  // interrupt over return over jump
  assign fetch_load_address = int_redirect ? int_fetch_address :
                              ret_redirect ? iretd_pop_data : jmp_addr_q;
  assign reg_cs             = int_redirect ? int_cs :
                              ret_load_cs  ? ret_cs : jmp_cs_q;

  // only the return path writes eflags and eip
  assign reg_load_eflags = ret_load_eflags;
  assign reg_eflags      = iretd_pop_data;
  assign reg_load_eip    = ret_load_eip;
  assign reg_eip         = iretd_pop_data;

  a_one_redirect: assert property (@(posedge or_int_vec) disable iff (!rst_n)
    $onehot0({int_redirect, ret_redirect, jmp_q}));

endmodule

//--- rtl/ret_frame.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module ret_frame import ret_pkg::*; (
  input  ret_step_t          step,
  input  logic               iretd_pop_valid,
  input  logic [`ADDR_W-1:0] iretd_pop_data,
  output logic               ret_load_eflags,
  output logic               ret_load_cs,
  output logic               ret_load_eip,
  output logic [`SEL_W-1:0]  ret_cs,
  output logic               ret_redirect
);

  logic at_eflags;
  logic at_cs;
  logic at_eip;

  assign at_eflags = (step == ret_step_t'(`RET_STEP_EFLAGS));
  assign at_cs     = (step == ret_step_t'(`RET_STEP_CS));
  assign at_eip    = (step == ret_step_t'(`RET_STEP_EIP));

  // each pop commits in its own cycle
  assign ret_load_eflags = iretd_pop_valid && at_eflags;
  assign ret_load_cs     = iretd_pop_valid && at_cs;
  assign ret_load_eip    = iretd_pop_valid && at_eip;

  // selector sits in the low half of the popped word
  assign ret_cs = iretd_pop_data[`SEL_W-1:0];

  // eip pop ends the sequence and moves fetch
  assign ret_redirect = iretd_pop_valid && at_eip;

endmodule

//--- rtl/ret_pkg.sv
package ret_pkg;

  // pop step of iretd / far / near return, 0 when idle
  typedef logic [1:0] ret_step_t;

endpackage

//--- rtl/ret_step_counter.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module ret_step_counter import ret_pkg::*; (
  input  logic      or_int_vec,
  input  logic      rst_n,
  input  logic      iretd,
  input  logic      ret_far,
  input  logic      ret_near,
  input  logic      iretd_pop_valid,
  output ret_step_t step,
  output logic      iretd_halt
);

  always_ff @(posedge or_int_vec or negedge rst_n) begin
    if (!rst_n) begin
      step <= '0;
    end else if (step == '0) begin
      // start step depends on how much of the frame is popped
      if (iretd) step <= ret_step_t'(`RET_STEP_EFLAGS);
      else if (ret_far) step <= ret_step_t'(`RET_STEP_CS);
      else if (ret_near) step <= ret_step_t'(`RET_STEP_EIP);
    end else if (iretd_pop_valid) begin
      if (step == ret_step_t'(`RET_STEP_EIP)) step <= '0;
      else step <= ret_step_t'(step + 2'd1);
    end
  end

  assign iretd_halt = (step != '0);

  a_one_start: assert property (@(posedge or_int_vec) disable iff (!rst_n)
    $onehot0({iretd, ret_far, ret_near}));

endmodule

//--- rtl/sys_ctl_defs.svh
`ifndef SYS_CTL_DEFS_SVH
`define SYS_CTL_DEFS_SVH

// interrupt request lines
`define IRQ_LINES 16

// bus and selector widths
`define ADDR_W 32
`define SEL_W 16

// descriptor table layout
`define IDT_BASE 32'h4000
`define IDT_ENTRY_BYTES 8
`define IDT_HI_OFFSET 4

// return sequence pop steps, 0 is idle
`define RET_STEP_EFLAGS 1
`define RET_STEP_CS 2
`define RET_STEP_EIP 3

`endif

//--- rtl/sys_ctl_top.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module sys_ctl_top import int_pkg::*, ret_pkg::*; (
  input  logic               or_int_vec,
  input  logic               rst_n,
  input  irq_vec_t           int_vec,
  output logic               mem_valid,
  input  logic               mem_ready,
  output logic [`ADDR_W-1:0] mem_address,
  input  logic               mem_dp_valid,
  output logic               mem_dp_ready,
  input  logic [`ADDR_W-1:0] mem_dp_read_data,
  output logic               flush_fetch,
  output logic               flush_decode_0,
  output logic               flush_decode_1,
  output logic               flush_register,
  output logic               flush_address,
  output logic               flush_execute,
  output logic               flush_writeback,
  output logic               fetch_load,
  output logic [`ADDR_W-1:0] fetch_load_address,
  output logic               decode_start_int,
  input  logic               decode_end_int,
  output logic               reg_load_cs,
  output logic [`SEL_W-1:0]  reg_cs,
  input  logic               ret_near,
  input  logic               ret_far,
  input  logic               iretd,
  output logic               iretd_halt,
  input  logic               iretd_pop_valid,
  input  logic [`ADDR_W-1:0] iretd_pop_data,
  output logic               reg_load_eflags,
  output logic [`ADDR_W-1:0] reg_eflags,
  output logic               reg_load_eip,
  output logic [`ADDR_W-1:0] reg_eip,
  output logic               pending_int,
  input  logic               hold_int,
  input  logic               jump_load,
  input  logic [`ADDR_W-1:0] jump_load_address,
  input  logic               jump_load_cs,
  input  logic [`SEL_W-1:0]  jump_cs
);

  irq_idx_t           svc_idx;
  logic               grant;
  logic               int_clear;
  logic               hi_sel;
  logic               capture_lo;
  logic               int_redirect;
  logic [`ADDR_W-1:0] int_fetch_address;
  logic [`SEL_W-1:0]  int_cs;
  ret_step_t          step;
  logic               ret_load_eflags;
  logic               ret_load_cs;
  logic               ret_load_eip;
  logic               ret_redirect;
  logic [`SEL_W-1:0]  ret_cs;

  //////////////////////////////////////////////////
  // interrupt path

  int_pending u_pending (
    .or_int_vec  (or_int_vec),
    .rst_n       (rst_n),
    .int_vec     (int_vec),
    .grant       (grant),
    .int_clear   (int_clear),
    .pending_int (pending_int),
    .svc_idx     (svc_idx)
  );

  int_seq_fsm u_seq (
    .or_int_vec       (or_int_vec),
    .rst_n            (rst_n),
    .pending_int      (pending_int),
    .hold_int         (hold_int),
    .ret_busy         (iretd_halt),
    .mem_ready        (mem_ready),
    .mem_dp_valid     (mem_dp_valid),
    .mem_valid        (mem_valid),
    .mem_dp_ready     (mem_dp_ready),
    .hi_sel           (hi_sel),
    .capture_lo       (capture_lo),
    .grant            (grant),
    .int_clear        (int_clear),
    .int_redirect     (int_redirect),
    .decode_start_int (decode_start_int),
    .decode_end_int   (decode_end_int)
  );

  idt_fetch u_idt (
    .or_int_vec        (or_int_vec),
    .rst_n             (rst_n),
    .svc_idx           (svc_idx),
    .hi_sel            (hi_sel),
    .capture_lo        (capture_lo),
    .mem_dp_read_data  (mem_dp_read_data),
    .mem_address       (mem_address),
    .int_fetch_address (int_fetch_address),
    .int_cs            (int_cs)
  );

  //////////////////////////////////////////////////
  // return path

  ret_step_counter u_ret_cnt (
    .or_int_vec      (or_int_vec),
    .rst_n           (rst_n),
    .iretd           (iretd),
    .ret_far         (ret_far),
    .ret_near        (ret_near),
    .iretd_pop_valid (iretd_pop_valid),
    .step            (step),
    .iretd_halt      (iretd_halt)
  );

  ret_frame u_ret_frame (
    .step            (step),
    .iretd_pop_valid (iretd_pop_valid),
    .iretd_pop_data  (iretd_pop_data),
    .ret_load_eflags (ret_load_eflags),
    .ret_load_cs     (ret_load_cs),
    .ret_load_eip    (ret_load_eip),
    .ret_cs          (ret_cs),
    .ret_redirect    (ret_redirect)
  );

  //////////////////////////////////////////////////
  // jump register and merge

  redirect_merge u_merge (
    .or_int_vec         (or_int_vec),
    .rst_n              (rst_n),
    .int_redirect       (int_redirect),
    .int_fetch_address  (int_fetch_address),
    .int_cs             (int_cs),
    .iretd_halt         (iretd_halt),
    .ret_load_eflags    (ret_load_eflags),
    .ret_load_cs        (ret_load_cs),
    .ret_load_eip       (ret_load_eip),
    .ret_redirect       (ret_redirect),
    .ret_cs             (ret_cs),
    .iretd_pop_data     (iretd_pop_data),
    .jump_load          (jump_load),
    .jump_load_address  (jump_load_address),
    .jump_load_cs       (jump_load_cs),
    .jump_cs            (jump_cs),
    .flush_fetch        (flush_fetch),
    .flush_decode_0     (flush_decode_0),
    .flush_decode_1     (flush_decode_1),
    .flush_register     (flush_register),
    .flush_address      (flush_address),
    .flush_execute      (flush_execute),
    .flush_writeback    (flush_writeback),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .reg_load_eflags    (reg_load_eflags),
    .reg_eflags         (reg_eflags),
    .reg_load_eip       (reg_load_eip),
    .reg_eip            (reg_eip)
  );

endmodule

//--- sys_ctl_top.f
+incdir+rtl
rtl/int_pkg.sv
rtl/ret_pkg.sv
rtl/int_pending.sv
rtl/int_seq_fsm.sv
rtl/idt_fetch.sv
rtl/ret_step_counter.sv
rtl/ret_frame.sv
rtl/redirect_merge.sv
rtl/sys_ctl_top.sv
verification/sys_ctl_tb.sv

//--- verification/sys_ctl_tb.sv
`timescale 1ns/10ps
`include "sys_ctl_defs.svh"

module sys_ctl_tb import int_pkg::*;;

  // ~10 services and returns, each well under 100 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  // flush order: fetch, decode_0, decode_1, register, address, execute, writeback
  localparam logic [6:0] FLUSH_INT  = 7'b1111111;
  localparam logic [6:0] FLUSH_RET  = 7'b1111100;
  localparam logic [6:0] FLUSH_JUMP = 7'b1111110;

  typedef struct packed {
    logic               from_int;
    logic [6:0]         flush;
    logic               load_cs;
    logic [`SEL_W-1:0]  cs;
    logic [`ADDR_W-1:0] addr;
  } redir_t;

  logic               clk;
  logic               rst_n;
  irq_vec_t           int_vec;
  logic               mem_valid;
  logic               mem_ready;
  logic [`ADDR_W-1:0] mem_address;
  logic               mem_dp_valid;
  logic               mem_dp_ready;
  logic [`ADDR_W-1:0] mem_dp_read_data;
  logic               flush_fetch;
  logic               flush_decode_0;
  logic               flush_decode_1;
  logic               flush_register;
  logic               flush_address;
  logic               flush_execute;
  logic               flush_writeback;
  logic               fetch_load;
  logic [`ADDR_W-1:0] fetch_load_address;
  logic               decode_start_int;
  logic               decode_end_int;
  logic               reg_load_cs;
  logic [`SEL_W-1:0]  reg_cs;
  logic               ret_near;
  logic               ret_far;
  logic               iretd;
  logic               iretd_halt;
  logic               iretd_pop_valid;
  logic [`ADDR_W-1:0] iretd_pop_data;
  logic               reg_load_eflags;
  logic [`ADDR_W-1:0] reg_eflags;
  logic               reg_load_eip;
  logic [`ADDR_W-1:0] reg_eip;
  logic               pending_int;
  logic               hold_int;
  logic               jump_load;
  logic [`ADDR_W-1:0] jump_load_address;
  logic               jump_load_cs;
  logic [`SEL_W-1:0]  jump_cs;

  logic [6:0]  flushes;
  logic [15:0] ctrl_outs;
  logic [31:0] stim_rs;
  logic [3:0]  exp_lines[$];
  redir_t      redir_q[$];
  int          err_cnt;
  int          test_base;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  logic        start_due;

  assign flushes = {flush_fetch, flush_decode_0, flush_decode_1, flush_register,
                    flush_address, flush_execute, flush_writeback};
  assign ctrl_outs = {mem_valid, mem_dp_ready, flushes, fetch_load, decode_start_int,
                      reg_load_cs, reg_load_eflags, reg_load_eip, iretd_halt, pending_int};

  sys_ctl_top u_dut (
    .or_int_vec (clk),
    .*
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random numbers and reference model

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(inout logic [31:0] s, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_step(s);
      v = {v[30:0], s[0]};
    end
  endtask

  function automatic logic [31:0] idt_addr(input logic [3:0] line, input logic hi);
    return `IDT_BASE + 32'(line) * `IDT_ENTRY_BYTES + (hi ? `IDT_HI_OFFSET : 0);
  endfunction

  // table contents, every address gives its own word
  function automatic logic [31:0] desc_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic redir_t int_redirect_exp(input logic [3:0] line);
    redir_t r;
    logic [31:0] lo;
    logic [31:0] hi;
    lo = swap_bytes(desc_word(idt_addr(line, 1'b0)));
    hi = swap_bytes(desc_word(idt_addr(line, 1'b1)));
    r.from_int = 1'b1;
    r.flush    = FLUSH_INT;
    r.load_cs  = 1'b1;
    r.cs       = hi[31:16];
    r.addr     = {16'h0000, lo[15:0]};
    return r;
  endfunction

  function automatic redir_t ret_redirect_exp(input logic [31:0] data);
    redir_t r;
    r.from_int = 1'b0;
    r.flush    = FLUSH_RET;
    r.load_cs  = 1'b0;
    r.cs       = '0;
    r.addr     = data;
    return r;
  endfunction

  function automatic redir_t jump_redirect_exp(input logic [31:0] addr, input logic with_cs,
                                               input logic [15:0] cs);
    redir_t r;
    r.from_int = 1'b0;
    r.flush    = FLUSH_JUMP;
    r.load_cs  = with_cs;
    r.cs       = cs;
    r.addr     = addr;
    return r;
  endfunction

  // {eflags, cs, eip} strobes for a pop at this step
  function automatic logic [2:0] ret_loads(input int step);
    return (step == 1) ? 3'b100 : (step == 2) ? 3'b010 : 3'b001;
  endfunction

  //////////////////////////////////////////////////
  // reporting

  task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("error %s: got 0x%h, expected 0x%h at %0t", sig, got, exp, $time);
    err_cnt++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    err_cnt++;
  endtask

  task automatic finish_test(input string name);
    if (redir_q.size() != 0) note_failure("a redirect was expected but fetch_load never came");
    if (exp_lines.size() != 0) note_failure("an expected table read never happened");
    redir_q.delete();
    exp_lines.delete();
    tests_run++;
    if (err_cnt == test_base) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, err_cnt - test_base);
    end
    test_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // responders and compare process

  initial begin : mem_responder
    logic [31:0] rs;
    logic [31:0] d;
    logic [31:0] addr;
    logic [31:0] want;
    logic        hi_phase;
    rs = 32'h3058;
    hi_phase = 1'b0;
    mem_ready = 1'b0;
    mem_dp_valid = 1'b0;
    mem_dp_read_data = '0;
    forever begin
      @(negedge clk);
      if (mem_valid === 1'b1) begin
        addr = mem_address;
        want = addr;
        if (exp_lines.size() == 0) begin
          note_failure("table read started with no interrupt expected");
        end else begin
          want = idt_addr(exp_lines[0], hi_phase);
          if (hi_phase) void'(exp_lines.pop_front());
        end
        if (addr !== want) value_error("mem_address", addr, want);
        draw(rs, 2, d);
        repeat (d) begin
          @(negedge clk);
          if (mem_address !== addr) value_error("mem_address", mem_address, addr);
        end
        mem_ready = 1'b1;
        @(negedge clk);
        mem_ready = 1'b0;
        draw(rs, 2, d);
        repeat (d) @(negedge clk);
        if (mem_dp_ready !== 1'b1) value_error("mem_dp_ready", 32'(mem_dp_ready), 32'd1);
        mem_dp_valid = 1'b1;
        mem_dp_read_data = desc_word(addr);
        @(negedge clk);
        mem_dp_valid = 1'b0;
        hi_phase = !hi_phase;
      end
    end
  end

  initial begin : decode_responder
    logic [31:0] rs;
    logic [31:0] d;
    rs = 32'h3058;
    decode_end_int = 1'b0;
    forever begin
      @(negedge clk);
      if (decode_start_int === 1'b1) begin
        draw(rs, 2, d);
        repeat (d) @(negedge clk);
        decode_end_int = 1'b1;
        @(negedge clk);
        decode_end_int = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : compare_redirects
    redir_t e;
    if (rst_n === 1'b1) begin
      if (start_due) begin
        if (decode_start_int !== 1'b1) begin
          value_error("decode_start_int", 32'(decode_start_int), 32'd1);
        end
        start_due = 1'b0;
      end
      if (fetch_load === 1'b1) begin
        if (redir_q.size() == 0) begin
          note_failure("fetch_load pulsed with no redirect pending");
        end else begin
          e = redir_q.pop_front();
          if (fetch_load_address !== e.addr) begin
            value_error("fetch_load_address", fetch_load_address, e.addr);
          end
          if (flushes !== e.flush) value_error("flushes", 32'(flushes), 32'(e.flush));
          if (reg_load_cs !== e.load_cs) begin
            value_error("reg_load_cs", 32'(reg_load_cs), 32'(e.load_cs));
          end
          if (e.load_cs && reg_cs !== e.cs) value_error("reg_cs", 32'(reg_cs), 32'(e.cs));
          start_due = e.from_int;
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without reaching the end", cycles);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // tests

  task automatic expect_service(input logic [3:0] line);
    exp_lines.push_back(line);
    redir_q.push_back(int_redirect_exp(line));
  endtask

  // returns at the falling edge after decode reports the end
  task automatic wait_service_end();
    do @(posedge clk); while (decode_end_int !== 1'b1);
    @(negedge clk);
  endtask

  task automatic expect_no_read(input int n);
    repeat (n) begin
      @(posedge clk);
      if (mem_valid !== 1'b0) value_error("mem_valid", 32'(mem_valid), 32'd0);
    end
    @(negedge clk);
  endtask

  task automatic single_interrupt();
    logic [31:0] r;
    draw(stim_rs, 4, r);
    expect_service(r[3:0]);
    int_vec = irq_vec_t'(1) << r[3:0];
    @(negedge clk);
    int_vec = '0;
    if (pending_int !== 1'b1) value_error("pending_int", 32'(pending_int), 32'd1);
    wait_service_end();
    if (pending_int !== 1'b0) value_error("pending_int", 32'(pending_int), 32'd0);
  endtask

  task automatic two_lines();
    logic [31:0] r;
    logic [3:0]  lo;
    logic [3:0]  hi;
    draw(stim_rs, 3, r);
    lo = {1'b0, r[2:0]};
    draw(stim_rs, 3, r);
    hi = {1'b1, r[2:0]};
    expect_service(lo);
    expect_service(hi);
    int_vec = (irq_vec_t'(1) << lo) | (irq_vec_t'(1) << hi);
    @(negedge clk);
    int_vec = '0;
    wait_service_end();
    wait_service_end();
    if (pending_int !== 1'b0) value_error("pending_int", 32'(pending_int), 32'd0);
  endtask

  task automatic blocked_interrupt();
    logic [31:0] r;
    hold_int = 1'b1;
    draw(stim_rs, 4, r);
    expect_service(r[3:0]);
    int_vec = irq_vec_t'(1) << r[3:0];
    @(negedge clk);
    int_vec = '0;
    expect_no_read(8);
    if (pending_int !== 1'b1) value_error("pending_int", 32'(pending_int), 32'd1);
    hold_int = 1'b0;
    wait_service_end();
    // near return in flight holds off the next service
    ret_near = 1'b1;
    @(negedge clk);
    ret_near = 1'b0;
    draw(stim_rs, 4, r);
    int_vec = irq_vec_t'(1) << r[3:0];
    @(negedge clk);
    int_vec = '0;
    expect_no_read(6);
    redir_q.push_back(ret_redirect_exp(32'h0000_8000 | r));
    expect_service(r[3:0]);
    iretd_pop_valid = 1'b1;
    iretd_pop_data = 32'h0000_8000 | r;
    @(negedge clk);
    iretd_pop_valid = 1'b0;
    wait_service_end();
  endtask

  task automatic run_return(input int kind);
    logic [31:0] r;
    logic [31:0] data;
    logic [2:0]  want;
    int          step;
    step = kind + 1;
    iretd = (kind == 0);
    ret_far = (kind == 1);
    ret_near = (kind == 2);
    @(negedge clk);
    iretd = 1'b0;
    ret_far = 1'b0;
    ret_near = 1'b0;
    while (step <= 3) begin
      draw(stim_rs, 2, r);
      repeat (r) begin
        @(posedge clk);
        if (iretd_halt !== 1'b1) value_error("iretd_halt", 32'(iretd_halt), 32'd1);
        if ({reg_load_eflags, reg_load_cs, reg_load_eip} !== 3'b000) begin
          value_error("reg_load strobes", 32'({reg_load_eflags, reg_load_cs, reg_load_eip}), 0);
        end
        @(negedge clk);
      end
      draw(stim_rs, 32, data);
      want = ret_loads(step);
      if (step == 3) redir_q.push_back(ret_redirect_exp(data));
      iretd_pop_valid = 1'b1;
      iretd_pop_data = data;
      @(posedge clk);
      if (iretd_halt !== 1'b1) value_error("iretd_halt", 32'(iretd_halt), 32'd1);
      if ({reg_load_eflags, reg_load_cs, reg_load_eip} !== want) begin
        value_error("reg_load strobes", 32'({reg_load_eflags, reg_load_cs, reg_load_eip}),
                    32'(want));
      end
      if (want[2] && reg_eflags !== data) value_error("reg_eflags", reg_eflags, data);
      if (want[1] && reg_cs !== data[15:0]) value_error("reg_cs", 32'(reg_cs), 32'(data[15:0]));
      if (want[0] && reg_eip !== data) value_error("reg_eip", reg_eip, data);
      @(negedge clk);
      iretd_pop_valid = 1'b0;
      step++;
    end
    if (iretd_halt !== 1'b0) value_error("iretd_halt", 32'(iretd_halt), 32'd0);
  endtask

  task automatic run_jump(input logic with_cs);
    logic [31:0] addr;
    logic [31:0] cs;
    draw(stim_rs, 32, addr);
    draw(stim_rs, 16, cs);
    jump_load = 1'b1;
    jump_load_address = addr;
    jump_cs = cs[15:0];
    jump_load_cs = with_cs;
    redir_q.push_back(jump_redirect_exp(addr, with_cs, cs[15:0]));
    @(posedge clk);
    if (fetch_load !== 1'b0) value_error("fetch_load", 32'(fetch_load), 32'd0);
    @(negedge clk);
    jump_load = 1'b0;
    jump_load_cs = 1'b0;
    @(posedge clk);
    if (fetch_load !== 1'b1) value_error("fetch_load", 32'(fetch_load), 32'd1);
    @(negedge clk);
  endtask

  initial begin : main
    stim_rs = 32'h3058;
    err_cnt = 0;
    test_base = 0;
    tests_run = 0;
    tests_failed = 0;
    start_due = 1'b0;
    rst_n = 1'b0;
    int_vec = '0;
    hold_int = 1'b0;
    iretd = 1'b0;
    ret_far = 1'b0;
    ret_near = 1'b0;
    iretd_pop_valid = 1'b0;
    iretd_pop_data = '0;
    jump_load = 1'b0;
    jump_load_address = '0;
    jump_load_cs = 1'b0;
    jump_cs = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(posedge clk);
    if (ctrl_outs !== '0) value_error("control outputs", 32'(ctrl_outs), 32'd0);
    @(negedge clk);
    finish_test("reset");

    repeat (3) single_interrupt();
    finish_test("single_interrupt");

    two_lines();
    finish_test("two_lines");

    blocked_interrupt();
    finish_test("blocked_interrupt");

    run_return(0);
    run_return(1);
    run_return(2);
    finish_test("returns");

    run_jump(1'b1);
    run_jump(1'b0);
    repeat (2) @(negedge clk);
    finish_test("jumps");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
